// File: sim.f
src/ul_pack_pkg.sv
src/ul_frame_writer.sv
src/ul_frame_buffer.sv
src/ul_sample_packer.sv
src/ul_cpri_mapper.sv
src/ul_package_data.sv
bench/tb_ul_package_data.sv

// File: Makefile
SRCS := $(wildcard src/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_ul_package_data: sim.f $(SRCS)
	verilator --binary --assert --top-module tb_ul_package_data -f sim.f

run: obj_dir/Vtb_ul_package_data
	./obj_dir/Vtb_ul_package_data | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_ul_package_data.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ul_package_data;
    import ul_pack_pkg::*;

    localparam int NUM_FRAMES      = 4;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 300;

    logic        clk;
    logic        rst;
    logic        i_vld;
    logic        i_sop;
    beat_t       i_ant_data;
    logic [3:0]  i_ch_type;
    logic        i_cell_idx;
    logic [6:0]  i_slot_idx;
    logic [3:0]  i_sym_idx;
    logic [8:0]  i_prb_idx;
    logic [7:0]  i_info;
    logic [1:0]  i_aiu_idx;
    logic [2:0]  i_lane_idx;
    logic [3:0]  i_rbg_idx;
    logic [31:0] i_fft_agc;
    logic        o_cpri_wen;
    addr_t       o_cpri_waddr;
    word_t       o_cpri_wdata;
    logic        o_cpri_wlast;

    // reference model and scoreboard state
    logic [31:0] lcg_state;
    beat_t       sent_beats [FRAME_BEATS];
    addr_t       exp_addr_q [$];
    word_t       exp_data_q [$];
    logic        exp_last_q [$];
    logic        seen [FRAME_BEATS];
    addr_t       e_addr;
    word_t       e_data;
    logic        e_last;
    int          errors;
    int          err_base;
    int          frames_sent;
    int          frames_out;
    int          frame_writes;
    int          tests_run;

    ul_package_data i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_vld        (i_vld),
        .i_sop        (i_sop),
        .i_ant_data   (i_ant_data),
        .i_ch_type    (i_ch_type),
        .i_cell_idx   (i_cell_idx),
        .i_slot_idx   (i_slot_idx),
        .i_sym_idx    (i_sym_idx),
        .i_prb_idx    (i_prb_idx),
        .i_info       (i_info),
        .i_aiu_idx    (i_aiu_idx),
        .i_lane_idx   (i_lane_idx),
        .i_rbg_idx    (i_rbg_idx),
        .i_fft_agc    (i_fft_agc),
        .o_cpri_wen   (o_cpri_wen),
        .o_cpri_waddr (o_cpri_waddr),
        .o_cpri_wdata (o_cpri_wdata),
        .o_cpri_wlast (o_cpri_wlast)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic drive_header();
        logic [31:0] r;
        r = next_rand();
        i_ch_type  = r[31:28];
        i_cell_idx = r[27];
        i_slot_idx = r[26:20];
        i_sym_idx  = r[19:16];
        r = next_rand();
        i_prb_idx  = r[31:23];
        i_info     = r[22:15];
        i_aiu_idx  = r[14:13];
        i_lane_idx = r[12:10];
        i_rbg_idx  = r[9:6];
        i_fft_agc  = next_rand();
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
            i_vld = 1'b0;
            i_sop = 1'b0;
        end
    endtask

    // slot per group, then seven lanes cut from the 112 bit group vector
    task automatic queue_expected(input word_t hdr, input word_t agc);
        logic [GROUP_BEATS*SAMPLE_W-1:0] vec [NUM_ANT];
        word_t w;
        for (int g = 0; g < GROUPS; g++)
        begin
            if (g < FIRST_SAMPLE_ADDR)
                exp_addr_q.push_back(addr_t'(g));
            else
                exp_addr_q.push_back(addr_t'(LAST_SAMPLE_ADDR + 1 + g - FIRST_SAMPLE_ADDR));
            if (g == 0)
                w = hdr;
            else if (g == 1)
                w = agc;
            else
                w = '0;
            exp_data_q.push_back(w);
            exp_last_q.push_back(1'b0);
            for (int a = 0; a < NUM_ANT; a++)
                for (int r = 0; r < GROUP_BEATS; r++)
                    vec[a][r*SAMPLE_W +: SAMPLE_W] =
                        sent_beats[g*GROUP_BEATS + r][a*SAMPLE_W +: SAMPLE_W];
            for (int k = 0; k < GROUP_BEATS - 1; k++)
            begin
                for (int a = 0; a < NUM_ANT; a++)
                    w[a*LANE_W +: LANE_W] = vec[a][k*LANE_W +: LANE_W];
                exp_addr_q.push_back(addr_t'(FIRST_SAMPLE_ADDR + g*(GROUP_BEATS-1) + k));
                exp_data_q.push_back(w);
                exp_last_q.push_back((g == GROUPS - 1) && (k == GROUP_BEATS - 2));
            end
        end
    endtask

    task automatic send_frame();
        logic [31:0] r;
        word_t hdr;
        word_t agc;
        for (int b = 0; b < FRAME_BEATS; b++)
        begin
            @(posedge clk);
            #1;
            if (b == 0)
                drive_header();
            for (int a = 0; a < NUM_ANT; a++)
            begin
                r = next_rand();
                sent_beats[b][a*SAMPLE_W +: SAMPLE_W] = r[31:18];
            end
            i_vld      = 1'b1;
            i_sop      = (b == 0);
            i_ant_data = sent_beats[b];
        end
        // header word 0 as laid out in the package
        hdr = '0;
        hdr[HDR_RBG_MSB:HDR_RBG_LSB]   = i_rbg_idx;
        hdr[HDR_AIU_MSB:HDR_AIU_LSB]   = i_aiu_idx;
        hdr[HDR_LANE_MSB:HDR_LANE_LSB] = i_lane_idx;
        hdr[HDR_CH_MSB:HDR_CH_LSB]     = i_ch_type;
        hdr[HDR_PRB_MSB:HDR_PRB_LSB]   = i_prb_idx[7:0];
        hdr[HDR_CELL]                  = i_cell_idx;
        hdr[HDR_SLOT_MSB:HDR_SLOT_LSB] = i_slot_idx;
        hdr[HDR_SYM_MSB:HDR_SYM_LSB]   = i_sym_idx;
        hdr[HDR_INFO_MSB:HDR_INFO_LSB] = i_info[7:4];
        agc = {32'h0, i_fft_agc};
        queue_expected(hdr, agc);
        frames_sent++;
    endtask

    task automatic wait_frames(input int count);
        while (frames_out < count)
            @(posedge clk);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %-14s done, %0d errors", name, errors - err_base);
        err_base = errors;
    endtask

    // ------------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------------
    task automatic close_frame();
        int missing;
        missing = 0;
        for (int i = 0; i < FRAME_BEATS; i++)
        begin
            if (!seen[i])
                missing++;
            seen[i] = 1'b0;
        end
        assert (frame_writes == FRAME_BEATS)
        else
        begin
            $display("ERROR frame_writes: got %h expected %h", frame_writes, FRAME_BEATS);
            errors++;
        end
        assert (missing == 0)
        else
        begin
            $display("frame %0d left %0d CPRI addresses unwritten", frames_out, missing);
            errors++;
        end
        frame_writes = 0;
        frames_out++;
    endtask

    // DUT writes against the model on the falling edge
    always @(negedge clk)
    begin
        if (!rst && o_cpri_wen)
        begin
            if (frames_sent == 0)
            begin
                $display("CPRI write seen before the first frame was sent, time %0t", $time);
                errors++;
            end
            else if (exp_addr_q.size() == 0)
            begin
                $display("unexpected CPRI write with no frame outstanding, time %0t", $time);
                errors++;
            end
            else
            begin
                e_addr = exp_addr_q.pop_front();
                e_data = exp_data_q.pop_front();
                e_last = exp_last_q.pop_front();
                assert (o_cpri_waddr == e_addr)
                else
                begin
                    $display("ERROR o_cpri_waddr: got %h expected %h", o_cpri_waddr, e_addr);
                    errors++;
                end
                assert (o_cpri_wdata == e_data)
                else
                begin
                    $display("ERROR o_cpri_wdata at addr %h: got %h expected %h",
                             e_addr, o_cpri_wdata, e_data);
                    errors++;
                end
                assert (o_cpri_wlast == e_last)
                else
                begin
                    $display("ERROR o_cpri_wlast: got %h expected %h", o_cpri_wlast, e_last);
                    errors++;
                end
                if (o_cpri_waddr <= addr_t'(FRAME_BEATS - 1))
                begin
                    assert (!seen[o_cpri_waddr])
                    else
                    begin
                        $display("CPRI address %0d written twice in one frame", o_cpri_waddr);
                        errors++;
                    end
                    seen[o_cpri_waddr] = 1'b1;
                end
                frame_writes++;
                // frame boundary as the DUT marks it
                if (o_cpri_wlast)
                    close_frame();
            end
        end
        else if (!rst && frame_writes != 0)
        begin
            $display("CPRI write burst broke off after %0d writes", frame_writes);
            errors++;
        end
    end

    a_quiet_in_reset : assert property (
        @(posedge clk) (rst && $past(rst)) |-> (!o_cpri_wen && !o_cpri_wlast))
    else
    begin
        $display("CPRI write port active during reset, time %0t", $time);
        errors++;
    end

    a_wlast_with_wen : assert property (
        @(posedge clk) disable iff (rst) o_cpri_wlast |-> o_cpri_wen)
    else
    begin
        $display("o_cpri_wlast raised without o_cpri_wen, time %0t", $time);
        errors++;
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        i_vld        = 1'b0;
        i_sop        = 1'b0;
        i_ant_data   = '0;
        i_ch_type    = '0;
        i_cell_idx   = 1'b0;
        i_slot_idx   = '0;
        i_sym_idx    = '0;
        i_prb_idx    = '0;
        i_info       = '0;
        i_aiu_idx    = '0;
        i_lane_idx   = '0;
        i_rbg_idx    = '0;
        i_fft_agc    = '0;
        lcg_state    = 32'h775c;
        errors       = 0;
        err_base     = 0;
        frames_sent  = 0;
        frames_out   = 0;
        frame_writes = 0;
        tests_run    = 0;
        for (int i = 0; i < FRAME_BEATS; i++)
            seen[i] = 1'b0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        drive_idle(16);
        report_test("reset");

        send_frame();
        drive_idle(1);
        wait_frames(1);
        report_test("single_frame");

        // no idle cycle between frames
        repeat (3) send_frame();
        drive_idle(1);
        wait_frames(NUM_FRAMES);
        drive_idle(8);
        report_test("back_to_back");

        if (exp_addr_q.size() != 0)
        begin
            $display("%0d expected CPRI writes never arrived", exp_addr_q.size());
            errors++;
        end
        $display("summary: %0d tests, %0d frames sent, %0d frames checked, %0d errors",
                 tests_run, frames_sent, frames_out, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d frames came out of the CPRI port",
                 WATCHDOG_CYCLES, frames_out, NUM_FRAMES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/ul_package_data.sv
`timescale 1ns/1ps
`default_nettype none

module ul_package_data (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_vld,
    input  wire                        i_sop,
    input  wire ul_pack_pkg::beat_t    i_ant_data,
    input  wire [3:0]                  i_ch_type,
    input  wire                        i_cell_idx,
    input  wire [6:0]                  i_slot_idx,
    input  wire [3:0]                  i_sym_idx,
    input  wire [8:0]                  i_prb_idx,
    input  wire [7:0]                  i_info,
    input  wire [1:0]                  i_aiu_idx,
    input  wire [2:0]                  i_lane_idx,
    input  wire [3:0]                  i_rbg_idx,
    input  wire [31:0]                 i_fft_agc,
    output logic                       o_cpri_wen,
    output ul_pack_pkg::addr_t         o_cpri_waddr,
    output ul_pack_pkg::word_t         o_cpri_wdata,
    output logic                       o_cpri_wlast
);
    import ul_pack_pkg::*;

    // writer -> buffer
    logic   wr_en;
    addr_t  wr_addr;
    beat_t  wr_data;
    logic   frame_done;
    word_t  wr_hdr_word;
    word_t  wr_agc_word;

    // buffer -> packer, mapper
    logic   rd_vld;
    beat_t  rd_beat;
    re_t    rd_re;
    group_t rd_group;
    word_t  rd_hdr_word;
    word_t  rd_agc_word;

    // packer -> mapper
    logic   pk_vld;
    word_t  pk_lanes;
    re_t    pk_re;
    group_t pk_group;

    ul_frame_writer u_writer (
        .clk          (clk),
        .rst          (rst),
        .i_vld        (i_vld),
        .i_sop        (i_sop),
        .i_ant_data   (i_ant_data),
        .i_ch_type    (i_ch_type),
        .i_cell_idx   (i_cell_idx),
        .i_slot_idx   (i_slot_idx),
        .i_sym_idx    (i_sym_idx),
        .i_prb_idx    (i_prb_idx),
        .i_info       (i_info),
        .i_aiu_idx    (i_aiu_idx),
        .i_lane_idx   (i_lane_idx),
        .i_rbg_idx    (i_rbg_idx),
        .i_fft_agc    (i_fft_agc),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_data    (wr_data),
        .o_frame_done (frame_done),
        .o_hdr_word   (wr_hdr_word),
        .o_agc_word   (wr_agc_word)
    );

    ul_frame_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .i_wr_en      (wr_en),
        .i_wr_addr    (wr_addr),
        .i_wr_data    (wr_data),
        .i_frame_done (frame_done),
        .i_hdr_word   (wr_hdr_word),
        .i_agc_word   (wr_agc_word),
        .o_rd_vld     (rd_vld),
        .o_rd_beat    (rd_beat),
        .o_rd_re      (rd_re),
        .o_rd_group   (rd_group),
        .o_hdr_word   (rd_hdr_word),
        .o_agc_word   (rd_agc_word)
    );

    ul_sample_packer u_packer (
        .clk          (clk),
        .rst          (rst),
        .i_rd_vld     (rd_vld),
        .i_rd_beat    (rd_beat),
        .i_rd_re      (rd_re),
        .i_rd_group   (rd_group),
        .o_pk_vld     (pk_vld),
        .o_pk_lanes   (pk_lanes),
        .o_pk_re      (pk_re),
        .o_pk_group   (pk_group)
    );

    ul_cpri_mapper u_mapper (
        .clk          (clk),
        .rst          (rst),
        .i_pk_vld     (pk_vld),
        .i_pk_lanes   (pk_lanes),
        .i_pk_re      (pk_re),
        .i_pk_group   (pk_group),
        .i_hdr_word   (rd_hdr_word),
        .i_agc_word   (rd_agc_word),
        .o_cpri_wen   (o_cpri_wen),
        .o_cpri_waddr (o_cpri_waddr),
        .o_cpri_wdata (o_cpri_wdata),
        .o_cpri_wlast (o_cpri_wlast)
    );

endmodule

`default_nettype wire

// File: src/ul_cpri_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module ul_cpri_mapper (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_pk_vld,
    input  wire ul_pack_pkg::word_t    i_pk_lanes,
    input  wire ul_pack_pkg::re_t      i_pk_re,
    input  wire ul_pack_pkg::group_t   i_pk_group,
    input  wire ul_pack_pkg::word_t    i_hdr_word,
    input  wire ul_pack_pkg::word_t    i_agc_word,
    output logic                       o_cpri_wen,
    output ul_pack_pkg::addr_t         o_cpri_waddr,
    output ul_pack_pkg::word_t         o_cpri_wdata,
    output logic                       o_cpri_wlast
);
    import ul_pack_pkg::*;

    // control slots past the sample region start at LAST_SAMPLE_ADDR + 1
    localparam int TAIL_OFS = LAST_SAMPLE_ADDR + 1 - FIRST_SAMPLE_ADDR;

    addr_t samp_addr;
    addr_t slot_addr;
    word_t ctrl_word;
    logic  is_ctrl;

    assign is_ctrl = (i_pk_re == '0);

    always_comb
    begin
        if (i_pk_group < group_t'(FIRST_SAMPLE_ADDR))
            slot_addr = addr_t'(i_pk_group);
        else
            slot_addr = addr_t'(i_pk_group) + addr_t'(TAIL_OFS);
        case (i_pk_group)
            group_t'(0): ctrl_word = i_hdr_word;
            group_t'(1): ctrl_word = i_agc_word;
            default:     ctrl_word = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // running sample address, wraps 90 -> 7 for back to back frames
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            samp_addr    <= addr_t'(FIRST_SAMPLE_ADDR);
            o_cpri_wen   <= 1'b0;
            o_cpri_wlast <= 1'b0;
        end
        else
        begin
            o_cpri_wen   <= i_pk_vld;
            o_cpri_wlast <= i_pk_vld && (i_pk_re == re_t'(GROUP_BEATS - 1)) &&
                            (i_pk_group == group_t'(GROUPS - 1));
            if (i_pk_vld && !is_ctrl)
            begin
                if (samp_addr == addr_t'(LAST_SAMPLE_ADDR))
                    samp_addr <= addr_t'(FIRST_SAMPLE_ADDR);
                else
                    samp_addr <= samp_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        o_cpri_waddr <= is_ctrl ? slot_addr : samp_addr;
        o_cpri_wdata <= is_ctrl ? ctrl_word : i_pk_lanes;
    end

    // last write of a frame lands on the final sample address
    a_wlast_on_last_word : assert property (
        @(posedge clk) disable iff (rst)
        o_cpri_wlast |-> (o_cpri_wen && (o_cpri_waddr == addr_t'(LAST_SAMPLE_ADDR))));

endmodule

`default_nettype wire

// File: src/ul_sample_packer.sv
`timescale 1ns/1ps
`default_nettype none

module ul_sample_packer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_rd_vld,
    input  wire ul_pack_pkg::beat_t    i_rd_beat,
    input  wire ul_pack_pkg::re_t      i_rd_re,
    input  wire ul_pack_pkg::group_t   i_rd_group,
    output logic                       o_pk_vld,
    output ul_pack_pkg::word_t         o_pk_lanes,
    output ul_pack_pkg::re_t           o_pk_re,
    output ul_pack_pkg::group_t        o_pk_group
);
    import ul_pack_pkg::*;

    beat_t   prev_beat;
    word_t   lanes;
    sample_t cur_s;
    sample_t prev_s;
    logic [2*SAMPLE_W-1:0] pair;
    logic [2*SAMPLE_W-1:0] shifted;
    logic [4:0] shift;

    // previous sample still owes 14 - (2r - 2) bits
    assign shift = {1'b0, i_rd_re, 1'b0} - 5'd2;

    // ------------------------------------------------------------------------
    // 8 x 14 bit samples -> 7 x 16 bit lanes, per antenna
    // ------------------------------------------------------------------------
    always_comb
    begin
        lanes   = '0;
        cur_s   = '0;
        prev_s  = '0;
        pair    = '0;
        shifted = '0;
        for (int a = 0; a < NUM_ANT; a++)
        begin
            cur_s   = i_rd_beat[a*SAMPLE_W +: SAMPLE_W];
            prev_s  = prev_beat[a*SAMPLE_W +: SAMPLE_W];
            pair    = {cur_s, prev_s};
            shifted = pair >> shift;
            lanes[a*LANE_W +: LANE_W] = shifted[LANE_W-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            o_pk_vld <= 1'b0;
        else
            o_pk_vld <= i_rd_vld;
    end

    always_ff @(posedge clk)
    begin
        if (i_rd_vld)
            prev_beat <= i_rd_beat;
        // beat 0 only primes prev_beat
        o_pk_lanes <= (i_rd_re == '0) ? '0 : lanes;
        o_pk_re    <= i_rd_re;
        o_pk_group <= i_rd_group;
    end

endmodule

`default_nettype wire

// File: src/ul_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module ul_frame_buffer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_wr_en,
    input  wire ul_pack_pkg::addr_t    i_wr_addr,
    input  wire ul_pack_pkg::beat_t    i_wr_data,
    input  wire                        i_frame_done,
    input  wire ul_pack_pkg::word_t    i_hdr_word,
    input  wire ul_pack_pkg::word_t    i_agc_word,
    output logic                       o_rd_vld,
    output ul_pack_pkg::beat_t         o_rd_beat,
    output ul_pack_pkg::re_t           o_rd_re,
    output ul_pack_pkg::group_t        o_rd_group,
    output ul_pack_pkg::word_t         o_hdr_word,
    output ul_pack_pkg::word_t         o_agc_word
);
    import ul_pack_pkg::*;

    beat_t  mem [2][FRAME_BEATS];
    word_t  hdr_mem [2];
    word_t  agc_mem [2];
    logic [1:0] full;
    logic   wr_bank;
    logic   rd_bank;
    addr_t  rd_addr;
    re_t    rd_re;
    group_t rd_group;
    logic   rd_act;
    logic   rd_last;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (i_wr_en)
            mem[wr_bank][i_wr_addr] <= i_wr_data;
        if (i_frame_done)
        begin
            hdr_mem[wr_bank] <= i_hdr_word;
            agc_mem[wr_bank] <= i_agc_word;
        end
    end

    // a bank stays full from frame_done until its last read
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_bank <= 1'b0;
            full    <= '0;
        end
        else
        begin
            if (rd_last)
                full[rd_bank] <= 1'b0;
            if (i_frame_done)
            begin
                full[wr_bank] <= 1'b1;
                wr_bank       <= ~wr_bank;
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    assign rd_act  = full[rd_bank];
    assign rd_last = rd_act && (rd_addr == addr_t'(FRAME_BEATS - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_bank  <= 1'b0;
            rd_addr  <= '0;
            rd_re    <= '0;
            rd_group <= '0;
            o_rd_vld <= 1'b0;
        end
        else
        begin
            o_rd_vld <= rd_act;
            if (rd_act)
            begin
                rd_re <= rd_re + 1'b1;
                if (rd_re == re_t'(GROUP_BEATS - 1))
                begin
                    if (rd_group == group_t'(GROUPS - 1))
                        rd_group <= '0;
                    else
                        rd_group <= rd_group + 1'b1;
                end
                if (rd_last)
                begin
                    rd_addr <= '0;
                    rd_bank <= ~rd_bank;
                end
                else
                    rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // one cycle read latency, index tags ride along
    always_ff @(posedge clk)
    begin
        o_rd_beat  <= mem[rd_bank][rd_addr];
        o_rd_re    <= rd_re;
        o_rd_group <= rd_group;
    end

    // read bank only moves after its last read
    assign o_hdr_word = hdr_mem[rd_bank];
    assign o_agc_word = agc_mem[rd_bank];

    a_no_write_full : assert property (
        @(posedge clk) disable iff (rst) i_wr_en |-> !full[wr_bank]);
    a_no_overrun : assert property (
        @(posedge clk) disable iff (rst) i_frame_done |-> !(&full));

endmodule

`default_nettype wire

// File: src/ul_frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

module ul_frame_writer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_vld,
    input  wire                        i_sop,
    input  wire ul_pack_pkg::beat_t    i_ant_data,
    input  wire [3:0]                  i_ch_type,
    input  wire                        i_cell_idx,
    input  wire [6:0]                  i_slot_idx,
    input  wire [3:0]                  i_sym_idx,
    input  wire [8:0]                  i_prb_idx,
    input  wire [7:0]                  i_info,
    input  wire [1:0]                  i_aiu_idx,
    input  wire [2:0]                  i_lane_idx,
    input  wire [3:0]                  i_rbg_idx,
    input  wire [31:0]                 i_fft_agc,
    output logic                       o_wr_en,
    output ul_pack_pkg::addr_t         o_wr_addr,
    output ul_pack_pkg::beat_t         o_wr_data,
    output logic                       o_frame_done,
    output ul_pack_pkg::word_t         o_hdr_word,
    output ul_pack_pkg::word_t         o_agc_word
);
    import ul_pack_pkg::*;

    addr_t beat_cnt;
    word_t hdr_next;
    logic  last_beat;

    assign last_beat = i_vld && (beat_cnt == addr_t'(FRAME_BEATS - 1));

    // beat position within the frame, idle cycles restart it
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat_cnt     <= '0;
            o_wr_en      <= 1'b0;
            o_frame_done <= 1'b0;
        end
        else
        begin
            o_wr_en      <= i_vld;
            o_frame_done <= last_beat;
            if (i_vld && !last_beat)
                beat_cnt <= beat_cnt + 1'b1;
            else
                beat_cnt <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        o_wr_addr <= beat_cnt;
        o_wr_data <= i_ant_data;
    end

    // ------------------------------------------------------------------------
    // header capture on start of frame
    // ------------------------------------------------------------------------
    always_comb
    begin
        hdr_next                           = '0;
        hdr_next[HDR_RBG_MSB:HDR_RBG_LSB]   = i_rbg_idx;
        hdr_next[HDR_AIU_MSB:HDR_AIU_LSB]   = i_aiu_idx;
        hdr_next[HDR_LANE_MSB:HDR_LANE_LSB] = i_lane_idx;
        hdr_next[HDR_CH_MSB:HDR_CH_LSB]     = i_ch_type;
        hdr_next[HDR_PRB_MSB:HDR_PRB_LSB]   = i_prb_idx[7:0];
        hdr_next[HDR_CELL]                 = i_cell_idx;
        hdr_next[HDR_SLOT_MSB:HDR_SLOT_LSB] = i_slot_idx;
        hdr_next[HDR_SYM_MSB:HDR_SYM_LSB]   = i_sym_idx;
        hdr_next[HDR_INFO_MSB:HDR_INFO_LSB] = i_info[7:4];
    end

    // held until the next sop, so still valid when frame_done fires
    always_ff @(posedge clk)
    begin
        if (i_vld && i_sop)
        begin
            o_hdr_word <= hdr_next;
            o_agc_word <= {{(WORD_W - 32){1'b0}}, i_fft_agc};
        end
    end

    a_sop_at_frame_start : assert property (
        @(posedge clk) disable iff (rst) (i_vld && i_sop) |-> (beat_cnt == '0));

endmodule

`default_nettype wire

// File: src/ul_pack_pkg.sv
`default_nettype none

package ul_pack_pkg;

    // ------------------------------------------------------------------------
    // frame geometry
    // ------------------------------------------------------------------------
    localparam int FRAME_BEATS = 96;
    localparam int GROUP_BEATS = 8;
    localparam int GROUPS      = 12;
    localparam int NUM_ANT     = 4;
    localparam int SAMPLE_W    = 14;
    localparam int LANE_W      = 16;
    localparam int WORD_W      = 64;
    localparam int ADDR_W      = 7;

    // sample region of the cpri buffer, control slots sit on either side
    localparam int FIRST_SAMPLE_ADDR = 7;
    localparam int LAST_SAMPLE_ADDR  = 90;

    typedef logic [SAMPLE_W-1:0]         sample_t;
    // antenna 0 in the low bits
    typedef logic [NUM_ANT*SAMPLE_W-1:0] beat_t;
    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [ADDR_W-1:0]           addr_t;
    typedef logic [$clog2(GROUP_BEATS)-1:0] re_t;
    typedef logic [$clog2(GROUPS)-1:0]   group_t;

    // ------------------------------------------------------------------------
    // header word 0 layout, unlisted bits are zero
    // ------------------------------------------------------------------------
    localparam int HDR_RBG_MSB  = 51;
    localparam int HDR_RBG_LSB  = 48;
    localparam int HDR_AIU_MSB  = 44;
    localparam int HDR_AIU_LSB  = 43;
    localparam int HDR_LANE_MSB = 42;
    localparam int HDR_LANE_LSB = 40;
    localparam int HDR_CH_MSB   = 39;
    localparam int HDR_CH_LSB   = 36;
    localparam int HDR_PRB_MSB  = 35;
    localparam int HDR_PRB_LSB  = 28;
    localparam int HDR_CELL     = 19;
    localparam int HDR_SLOT_MSB = 18;
    localparam int HDR_SLOT_LSB = 12;
    localparam int HDR_SYM_MSB  = 11;
    localparam int HDR_SYM_LSB  = 8;
    localparam int HDR_INFO_MSB = 7;
    localparam int HDR_INFO_LSB = 4;

endpackage

`default_nettype wire
